//--- alu.sv
`include "ooo_core_defs.svh"

module alu (
   input  logic                  clk,
   input  logic                  nrst,
   input  logic                  i_valid,
   input  ooo_core_pkg::opcode_e i_op,
   input  ooo_core_pkg::rob_id_t i_tag,
   input  ooo_core_pkg::data_t   i_a,
   input  ooo_core_pkg::data_t   i_b,
   output logic                  o_cdb_valid,
   output ooo_core_pkg::rob_id_t o_cdb_tag,
   output ooo_core_pkg::data_t   o_cdb_data
);

   ooo_core_pkg::data_t   result;
   logic                  s1_valid;
   ooo_core_pkg::rob_id_t s1_tag;
   ooo_core_pkg::data_t   s1_data;

   always_comb begin
      case (i_op)
         ooo_core_pkg::OP_ADD, ooo_core_pkg::OP_ADDI: result = i_a + i_b;
         ooo_core_pkg::OP_SUB, ooo_core_pkg::OP_SUBI: result = i_a - i_b;
         ooo_core_pkg::OP_AND: result = i_a & i_b;
         ooo_core_pkg::OP_OR: result = i_a | i_b;
         ooo_core_pkg::OP_XOR: result = i_a ^ i_b;
         // SETI carries its immediate in b
         default: result = i_b;
      endcase
   end

   always_ff @(posedge clk) begin
      if (nrst) begin
         s1_valid <= 1'b0;
         o_cdb_valid <= 1'b0;
      end else begin
         s1_valid <= i_valid;
         o_cdb_valid <= s1_valid;
      end
   end

   always_ff @(posedge clk) begin
      s1_tag <= i_tag;
      s1_data <= result;
      o_cdb_tag <= s1_tag;
      o_cdb_data <= s1_data;
   end

endmodule

//--- dispatch.sv
`include "ooo_core_defs.svh"

module dispatch (
   input  ooo_core_pkg::instr_t         i_instr,
   input  logic                         i_instr_valid,
   input  logic                         i_rob_full,
   input  logic                         i_rs_full,
   input  ooo_core_pkg::rob_id_t        i_rob_tail,
   input  logic [1:0]                   i_rf_busy,
   input  ooo_core_pkg::rob_id_t [1:0]  i_rf_tag,
   input  ooo_core_pkg::data_t [1:0]    i_rf_data,
   input  logic [1:0]                   i_rob_done,
   input  ooo_core_pkg::data_t [1:0]    i_rob_data,
   input  logic                         i_cdb_valid,
   input  ooo_core_pkg::rob_id_t        i_cdb_tag,
   input  ooo_core_pkg::data_t          i_cdb_data,
   output logic                         o_instr_ready,
   output logic                         o_alloc,
   output ooo_core_pkg::reg_addr_t [1:0] o_rf_rd_addr,
   output ooo_core_pkg::rob_id_t [1:0]  o_rob_rd_tag,
   output ooo_core_pkg::reg_addr_t      o_dst_reg,
   output ooo_core_pkg::opcode_e        o_op,
   output logic [1:0]                   o_src_ready,
   output ooo_core_pkg::rob_id_t [1:0]  o_src_tag,
   output ooo_core_pkg::data_t [1:0]    o_src_data
);

   ooo_core_pkg::opcode_e op;

   assign op = ooo_core_pkg::opcode_e'(i_instr[15:12]);
   assign o_op = op;
   assign o_dst_reg = i_instr[11:9];
   assign o_rf_rd_addr[0] = i_instr[8:6];
   assign o_rf_rd_addr[1] = i_instr[5:3];
   assign o_rob_rd_tag = i_rf_tag;

   // Stall on structure fullness only
   assign o_instr_ready = !i_rob_full && !i_rs_full;
   assign o_alloc = i_instr_valid && o_instr_ready;

   always_comb begin
      for (int i = 0; i < 2; i++) begin
         // Ready operands park on the own tag, never a live broadcast
         o_src_tag[i] = i_rob_tail;
         o_src_ready[i] = 1'b1;
         if (!i_rf_busy[i]) begin
            o_src_data[i] = i_rf_data[i];
         end else if (i_rob_done[i]) begin
            o_src_data[i] = i_rob_data[i];
         end else if (i_cdb_valid && i_cdb_tag == i_rf_tag[i]) begin
            o_src_data[i] = i_cdb_data;
         end else begin
            o_src_ready[i] = 1'b0;
            o_src_tag[i] = i_rf_tag[i];
            o_src_data[i] = i_rf_data[i];
         end
      end

      case (op)
         ooo_core_pkg::OP_ADDI, ooo_core_pkg::OP_SUBI: begin
            o_src_ready[1] = 1'b1;
            o_src_tag[1] = i_rob_tail;
            o_src_data[1] = {{(`OOO_DATA_W-6){1'b0}}, i_instr[5:0]};
         end
         ooo_core_pkg::OP_SETI: begin
            o_src_ready = 2'b11;
            o_src_tag = {i_rob_tail, i_rob_tail};
            o_src_data[0] = '0;
            o_src_data[1] = {{(`OOO_DATA_W-9){1'b0}}, i_instr[8:0]};
         end
         default: begin
         end
      endcase
   end

endmodule

//--- ooo_core.f
+incdir+.
ooo_core_pkg.sv
dispatch.sv
register_file.sv
reorder_buffer.sv
reservation_station.sv
alu.sv
ooo_core.sv
ooo_core_checker.sv
tb_ooo_core.sv

//--- ooo_core.sv
module ooo_core (
   input  logic                    clk,
   input  logic                    nrst,
   input  ooo_core_pkg::instr_t    i_instr,
   input  logic                    i_instr_valid,
   output logic                    o_instr_ready,
   output logic                    o_commit_valid,
   output ooo_core_pkg::reg_addr_t o_commit_reg,
   output ooo_core_pkg::data_t     o_commit_data
);

   logic                         alloc;
   logic                         rob_full;
   logic                         rs_full;
   ooo_core_pkg::rob_id_t        rob_tail;
   ooo_core_pkg::reg_addr_t [1:0] rf_rd_addr;
   logic [1:0]                   rf_busy;
   ooo_core_pkg::rob_id_t [1:0]  rf_tag;
   ooo_core_pkg::data_t [1:0]    rf_data;
   ooo_core_pkg::rob_id_t [1:0]  rob_rd_tag;
   logic [1:0]                   rob_done;
   ooo_core_pkg::data_t [1:0]    rob_data;
   ooo_core_pkg::reg_addr_t      dst_reg;
   ooo_core_pkg::opcode_e        disp_op;
   logic [1:0]                   src_ready;
   ooo_core_pkg::rob_id_t [1:0]  src_tag;
   ooo_core_pkg::data_t [1:0]    src_data;
   logic                         cdb_valid;
   ooo_core_pkg::rob_id_t        cdb_tag;
   ooo_core_pkg::data_t          cdb_data;
   logic                         issue_valid;
   ooo_core_pkg::opcode_e        issue_op;
   ooo_core_pkg::rob_id_t        issue_tag;
   ooo_core_pkg::data_t          issue_a;
   ooo_core_pkg::data_t          issue_b;
   ooo_core_pkg::rob_id_t        commit_tag;

   dispatch dispatch0 (
      .i_instr(i_instr), .i_instr_valid(i_instr_valid),
      .i_rob_full(rob_full), .i_rs_full(rs_full), .i_rob_tail(rob_tail),
      .i_rf_busy(rf_busy), .i_rf_tag(rf_tag), .i_rf_data(rf_data),
      .i_rob_done(rob_done), .i_rob_data(rob_data),
      .i_cdb_valid(cdb_valid), .i_cdb_tag(cdb_tag), .i_cdb_data(cdb_data),
      .o_instr_ready(o_instr_ready), .o_alloc(alloc),
      .o_rf_rd_addr(rf_rd_addr), .o_rob_rd_tag(rob_rd_tag),
      .o_dst_reg(dst_reg), .o_op(disp_op), .o_src_ready(src_ready),
      .o_src_tag(src_tag), .o_src_data(src_data)
   );

   register_file register_file0 (
      .clk(clk), .nrst(nrst),
      .i_rd_addr(rf_rd_addr), .o_busy(rf_busy), .o_tag(rf_tag), .o_data(rf_data),
      .i_rename(alloc), .i_rename_reg(dst_reg), .i_rename_tag(rob_tail),
      .i_wb_valid(o_commit_valid), .i_wb_reg(o_commit_reg),
      .i_wb_tag(commit_tag), .i_wb_data(o_commit_data)
   );

   reorder_buffer reorder_buffer0 (
      .clk(clk), .nrst(nrst),
      .i_alloc(alloc), .i_dst_reg(dst_reg), .o_tail(rob_tail), .o_full(rob_full),
      .i_rd_tag(rob_rd_tag), .o_rd_done(rob_done), .o_rd_data(rob_data),
      .i_cdb_valid(cdb_valid), .i_cdb_tag(cdb_tag), .i_cdb_data(cdb_data),
      .o_commit_valid(o_commit_valid), .o_commit_reg(o_commit_reg),
      .o_commit_tag(commit_tag), .o_commit_data(o_commit_data)
   );

   reservation_station reservation_station0 (
      .clk(clk), .nrst(nrst),
      .i_alloc(alloc), .i_op(disp_op), .i_tag(rob_tail),
      .i_src_ready(src_ready), .i_src_tag(src_tag), .i_src_data(src_data),
      .i_cdb_valid(cdb_valid), .i_cdb_tag(cdb_tag), .i_cdb_data(cdb_data),
      .o_full(rs_full), .o_issue_valid(issue_valid), .o_issue_op(issue_op),
      .o_issue_tag(issue_tag), .o_issue_a(issue_a), .o_issue_b(issue_b)
   );

   alu alu0 (
      .clk(clk), .nrst(nrst),
      .i_valid(issue_valid), .i_op(issue_op), .i_tag(issue_tag),
      .i_a(issue_a), .i_b(issue_b),
      .o_cdb_valid(cdb_valid), .o_cdb_tag(cdb_tag), .o_cdb_data(cdb_data)
   );

endmodule

//--- ooo_core_checker.sv
module ooo_core_checker (
   input  logic                    clk,
   input  logic                    nrst,
   input  logic                    i_instr_valid,
   input  logic                    i_instr_ready,
   input  logic                    i_commit_valid,
   input  ooo_core_pkg::reg_addr_t i_commit_reg,
   input  ooo_core_pkg::data_t     i_commit_data,
   input  logic                    i_finish,
   output logic                    o_finished,
   output int                      o_commits,
   output int                      o_expected,
   output int                      o_value_errors,
   output int                      o_other_errors
);

   ooo_core_pkg::reg_addr_t exp_reg [$];
   ooo_core_pkg::data_t     exp_data [$];
   logic                    seen_accept;
   logic                    first_cycle;
   logic                    file_bad;
   int                      stalls;
   int                      verr;
   int                      oerr;
   int                      ncommit;
   int                      fd;
   int                      n;
   logic [7:0]              kind;
   logic [15:0]             f_reg;
   logic [15:0]             f_data;
   logic [8*128-1:0]        rest;

   // Expected commits are the C lines
   initial begin
      file_bad = 1'b0;
      fd = $fopen("ooo_core_golden.txt", "r");
      if (fd == 0) begin
         file_bad = 1'b1;
      end else begin
         while (!$feof(fd)) begin
            n = $fscanf(fd, " %c", kind);
            if (n == 1 && kind == "C") begin
               n = $fscanf(fd, "%h %h", f_reg, f_data);
               exp_reg.push_back(f_reg[2:0]);
               exp_data.push_back(f_data);
            end else if (n == 1) begin
               n = $fgets(rest, fd);
            end
         end
         $fclose(fd);
      end
      o_expected = exp_reg.size();
      if (o_expected == 0) begin
         file_bad = 1'b1;
      end
   end

   always @(posedge clk) begin
      if (nrst) begin
         seen_accept <= 1'b0;
         first_cycle <= 1'b1;
         o_finished <= 1'b0;
         stalls <= 0;
         verr = 0;
         oerr = 0;
         ncommit = 0;
      end else begin
         first_cycle <= 1'b0;
         if (first_cycle && i_instr_ready !== 1'b1) begin
            $display("error o_instr_ready: got %h expected %h", i_instr_ready, 1'b1);
            verr = verr + 1;
         end
         if (i_instr_valid && i_instr_ready) begin
            seen_accept <= 1'b1;
         end
         if (i_instr_valid && !i_instr_ready) begin
            stalls <= stalls + 1;
         end
         if (i_commit_valid) begin
            if (!seen_accept) begin
               $display("error o_commit_valid: got %h expected %h", i_commit_valid, 1'b0);
               verr = verr + 1;
            end else if (ncommit >= o_expected) begin
               $display("commit number %0d arrived beyond the %0d expected commits",
                        ncommit + 1, o_expected);
               oerr = oerr + 1;
            end else begin
               if (i_commit_reg !== exp_reg[ncommit]) begin
                  $display("error o_commit_reg: got %h expected %h (commit %0d)",
                           i_commit_reg, exp_reg[ncommit], ncommit);
                  verr = verr + 1;
               end
               if (i_commit_data !== exp_data[ncommit]) begin
                  $display("error o_commit_data: got %h expected %h (commit %0d)",
                           i_commit_data, exp_data[ncommit], ncommit);
                  verr = verr + 1;
               end
            end
            ncommit = ncommit + 1;
         end
         // Final checks once the run winds down
         if (i_finish && !o_finished) begin
            if (file_bad) begin
               $display("golden file could not be read or held no commits");
               oerr = oerr + 1;
            end
            if (ncommit < o_expected) begin
               $display("%0d of %0d expected commits never arrived",
                        o_expected - ncommit, o_expected);
               oerr = oerr + 1;
            end
            if (stalls == 0) begin
               $display("instruction port never stalled during the run");
               oerr = oerr + 1;
            end
            o_finished <= 1'b1;
         end
      end
      o_commits <= ncommit;
      o_value_errors <= verr;
      o_other_errors <= oerr;
   end

endmodule

//--- ooo_core_defs.svh
`ifndef OOO_CORE_DEFS_SVH
`define OOO_CORE_DEFS_SVH

// Register value width
`define OOO_DATA_W 16

// Architectural registers
`define OOO_NUM_REGS 8

// Reorder buffer slots, also the rename tag space
`define OOO_ROB_DEPTH 8

// ALU reservation station slots
`define OOO_RS_DEPTH 4

`endif

//--- ooo_core_golden.txt
# I <instruction word hex>, in program order
# C <rd> <value hex>, expected commits in program order
I 732A
I 74F5
I 567F
I 6801
I 0A50
I 1C88
I 2F18
I 3370
I 4478
I 06D8
I 06D8
I 06D8
I 06D8
I 06D8
I 06D8
I 7BFF
I 66E0
I 7605
I 58C2
C 1 012A
C 2 00F5
C 3 0169
C 4 FFFF
C 5 021F
C 6 FFCB
C 7 0169
C 1 FFDF
C 2 FEB6
C 3 02D2
C 3 05A4
C 3 0B48
C 3 1690
C 3 2D20
C 3 5A40
C 5 01FF
C 3 5A20
C 3 0005
C 4 0007

//--- ooo_core_pkg.sv
`include "ooo_core_defs.svh"

package ooo_core_pkg;

   typedef logic [`OOO_DATA_W-1:0] data_t;

   typedef logic [$clog2(`OOO_NUM_REGS)-1:0] reg_addr_t;

   // Slot index and rename tag share one type
   typedef logic [$clog2(`OOO_ROB_DEPTH)-1:0] rob_id_t;

   typedef logic [15:0] instr_t;

   typedef enum logic [3:0] {
      OP_ADD  = 4'h0,
      OP_SUB  = 4'h1,
      OP_AND  = 4'h2,
      OP_OR   = 4'h3,
      OP_XOR  = 4'h4,
      OP_ADDI = 4'h5,
      OP_SUBI = 4'h6,
      OP_SETI = 4'h7
   } opcode_e;

endpackage

//--- register_file.sv
`include "ooo_core_defs.svh"

module register_file (
   input  logic                          clk,
   input  logic                          nrst,
   input  ooo_core_pkg::reg_addr_t [1:0] i_rd_addr,
   output logic [1:0]                    o_busy,
   output ooo_core_pkg::rob_id_t [1:0]   o_tag,
   output ooo_core_pkg::data_t [1:0]     o_data,
   input  logic                          i_rename,
   input  ooo_core_pkg::reg_addr_t       i_rename_reg,
   input  ooo_core_pkg::rob_id_t         i_rename_tag,
   input  logic                          i_wb_valid,
   input  ooo_core_pkg::reg_addr_t       i_wb_reg,
   input  ooo_core_pkg::rob_id_t         i_wb_tag,
   input  ooo_core_pkg::data_t           i_wb_data
);

   ooo_core_pkg::data_t     regs [`OOO_NUM_REGS];
   ooo_core_pkg::rob_id_t   tags [`OOO_NUM_REGS];
   logic [`OOO_NUM_REGS-1:0] busy;

   always_ff @(posedge clk) begin
      if (nrst) begin
         busy <= '0;
         for (int i = 0; i < `OOO_NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else begin
         if (i_wb_valid) begin
            regs[i_wb_reg] <= i_wb_data;
            // Only the newest producer frees the register
            if (tags[i_wb_reg] == i_wb_tag) begin
               busy[i_wb_reg] <= 1'b0;
            end
         end
         if (i_rename) begin
            busy[i_rename_reg] <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (i_rename) begin
         tags[i_rename_reg] <= i_rename_tag;
      end
   end

   always_comb begin
      for (int i = 0; i < 2; i++) begin
         o_busy[i] = busy[i_rd_addr[i]];
         o_tag[i] = tags[i_rd_addr[i]];
         o_data[i] = regs[i_rd_addr[i]];
      end
   end

endmodule

//--- reorder_buffer.sv
`include "ooo_core_defs.svh"

module reorder_buffer (
   input  logic                         clk,
   input  logic                         nrst,
   input  logic                         i_alloc,
   input  ooo_core_pkg::reg_addr_t      i_dst_reg,
   output ooo_core_pkg::rob_id_t        o_tail,
   output logic                         o_full,
   input  ooo_core_pkg::rob_id_t [1:0]  i_rd_tag,
   output logic [1:0]                   o_rd_done,
   output ooo_core_pkg::data_t [1:0]    o_rd_data,
   input  logic                         i_cdb_valid,
   input  ooo_core_pkg::rob_id_t        i_cdb_tag,
   input  ooo_core_pkg::data_t          i_cdb_data,
   output logic                         o_commit_valid,
   output ooo_core_pkg::reg_addr_t      o_commit_reg,
   output ooo_core_pkg::rob_id_t        o_commit_tag,
   output ooo_core_pkg::data_t          o_commit_data
);

   logic [`OOO_ROB_DEPTH-1:0]       valid;
   logic [`OOO_ROB_DEPTH-1:0]       done;
   ooo_core_pkg::reg_addr_t         dst_reg [`OOO_ROB_DEPTH];
   ooo_core_pkg::data_t             value [`OOO_ROB_DEPTH];
   ooo_core_pkg::rob_id_t           head;
   ooo_core_pkg::rob_id_t           tail;
   logic [$clog2(`OOO_ROB_DEPTH):0] count;
   logic                            retire;

   assign retire = valid[head] && done[head];

   always_ff @(posedge clk) begin
      if (nrst) begin
         valid <= '0;
         done <= '0;
         head <= '0;
         tail <= '0;
         count <= '0;
      end else begin
         if (i_alloc) begin
            valid[tail] <= 1'b1;
            done[tail] <= 1'b0;
            tail <= tail + 1'b1;
         end
         if (i_cdb_valid) begin
            done[i_cdb_tag] <= 1'b1;
         end
         if (retire) begin
            valid[head] <= 1'b0;
            head <= head + 1'b1;
         end
         count <= count + i_alloc - retire;
      end
   end

   always_ff @(posedge clk) begin
      if (i_alloc) begin
         dst_reg[tail] <= i_dst_reg;
      end
      if (i_cdb_valid) begin
         value[i_cdb_tag] <= i_cdb_data;
      end
   end

   assign o_tail = tail;
   assign o_full = (count == `OOO_ROB_DEPTH);

   // Operand lookup for dispatch
   always_comb begin
      for (int i = 0; i < 2; i++) begin
         o_rd_done[i] = valid[i_rd_tag[i]] && done[i_rd_tag[i]];
         o_rd_data[i] = value[i_rd_tag[i]];
      end
   end

   assign o_commit_valid = retire;
   assign o_commit_reg = dst_reg[head];
   assign o_commit_tag = head;
   assign o_commit_data = value[head];

   a_no_alloc_full: assert property (@(posedge clk) disable iff (nrst)
      i_alloc |-> !o_full);

   a_cdb_live_slot: assert property (@(posedge clk) disable iff (nrst)
      i_cdb_valid |-> valid[i_cdb_tag] && !done[i_cdb_tag]);

endmodule

//--- reservation_station.sv
`include "ooo_core_defs.svh"

module reservation_station (
   input  logic                        clk,
   input  logic                        nrst,
   input  logic                        i_alloc,
   input  ooo_core_pkg::opcode_e       i_op,
   input  ooo_core_pkg::rob_id_t       i_tag,
   input  logic [1:0]                  i_src_ready,
   input  ooo_core_pkg::rob_id_t [1:0] i_src_tag,
   input  ooo_core_pkg::data_t [1:0]   i_src_data,
   input  logic                        i_cdb_valid,
   input  ooo_core_pkg::rob_id_t       i_cdb_tag,
   input  ooo_core_pkg::data_t         i_cdb_data,
   output logic                        o_full,
   output logic                        o_issue_valid,
   output ooo_core_pkg::opcode_e       o_issue_op,
   output ooo_core_pkg::rob_id_t       o_issue_tag,
   output ooo_core_pkg::data_t         o_issue_a,
   output ooo_core_pkg::data_t         o_issue_b
);

   logic [`OOO_RS_DEPTH-1:0]         valid;
   ooo_core_pkg::opcode_e            op [`OOO_RS_DEPTH];
   ooo_core_pkg::rob_id_t            tag [`OOO_RS_DEPTH];
   logic [1:0]                       rdy [`OOO_RS_DEPTH];
   ooo_core_pkg::rob_id_t [1:0]      src_tag [`OOO_RS_DEPTH];
   ooo_core_pkg::data_t [1:0]        src_data [`OOO_RS_DEPTH];
   logic [$clog2(`OOO_RS_DEPTH)-1:0] free_idx;
   logic [$clog2(`OOO_RS_DEPTH)-1:0] sel_idx;
   logic                             sel_found;

   // Lowest free slot and lowest ready slot
   always_comb begin
      free_idx = '0;
      sel_idx = '0;
      sel_found = 1'b0;
      for (int i = `OOO_RS_DEPTH - 1; i >= 0; i--) begin
         if (!valid[i]) begin
            free_idx = i[$clog2(`OOO_RS_DEPTH)-1:0];
         end
         if (valid[i] && rdy[i] == 2'b11) begin
            sel_idx = i[$clog2(`OOO_RS_DEPTH)-1:0];
            sel_found = 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (nrst) begin
         valid <= '0;
      end else begin
         if (sel_found) begin
            valid[sel_idx] <= 1'b0;
         end
         if (i_alloc) begin
            valid[free_idx] <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < `OOO_RS_DEPTH; i++) begin
         for (int s = 0; s < 2; s++) begin
            // Wakeup
            if (i_cdb_valid && valid[i] && !rdy[i][s] && src_tag[i][s] == i_cdb_tag) begin
               rdy[i][s] <= 1'b1;
               src_data[i][s] <= i_cdb_data;
            end
         end
      end
      if (i_alloc) begin
         op[free_idx] <= i_op;
         tag[free_idx] <= i_tag;
         rdy[free_idx] <= i_src_ready;
         src_tag[free_idx] <= i_src_tag;
         src_data[free_idx] <= i_src_data;
      end
   end

   assign o_full = &valid;
   assign o_issue_valid = sel_found;
   assign o_issue_op = op[sel_idx];
   assign o_issue_tag = tag[sel_idx];
   assign o_issue_a = src_data[sel_idx][0];
   assign o_issue_b = src_data[sel_idx][1];

   // A new entry never overwrites an occupied slot
   a_alloc_free_slot: assert property (@(posedge clk) disable iff (nrst)
      i_alloc |-> !valid[free_idx]);

endmodule

//--- tb_ooo_core.sv
module tb_ooo_core;

   localparam int READY_TIMEOUT = 100;
   localparam int COMMIT_TIMEOUT = 400;
   localparam int FINISH_TIMEOUT = 10;

   logic                    clk;
   logic                    nrst;
   ooo_core_pkg::instr_t    i_instr;
   logic                    i_instr_valid;
   logic                    o_instr_ready;
   logic                    o_commit_valid;
   ooo_core_pkg::reg_addr_t o_commit_reg;
   ooo_core_pkg::data_t     o_commit_data;
   logic                    finish;
   logic                    finished;
   int                      commits;
   int                      expected;
   int                      value_errors;
   int                      other_errors;
   ooo_core_pkg::instr_t    program_q [$];
   int                      seed;
   int                      tb_errors;
   int                      r;
   bit                      aborted;
   bit                      accepted;

   always #2 clk = ~clk;

   ooo_core dut0 (
      .clk(clk), .nrst(nrst),
      .i_instr(i_instr), .i_instr_valid(i_instr_valid), .o_instr_ready(o_instr_ready),
      .o_commit_valid(o_commit_valid), .o_commit_reg(o_commit_reg),
      .o_commit_data(o_commit_data)
   );

   ooo_core_checker chk0 (
      .clk(clk), .nrst(nrst),
      .i_instr_valid(i_instr_valid), .i_instr_ready(o_instr_ready),
      .i_commit_valid(o_commit_valid), .i_commit_reg(o_commit_reg),
      .i_commit_data(o_commit_data),
      .i_finish(finish), .o_finished(finished), .o_commits(commits),
      .o_expected(expected), .o_value_errors(value_errors),
      .o_other_errors(other_errors)
   );

   // Instruction words are the I lines
   task automatic load_program();
      int               fd;
      int               n;
      logic [7:0]       kind;
      logic [15:0]      word;
      logic [8*128-1:0] rest;
      fd = $fopen("ooo_core_golden.txt", "r");
      if (fd == 0) begin
         $display("cannot open ooo_core_golden.txt");
         tb_errors++;
         aborted = 1'b1;
      end else begin
         while (!$feof(fd)) begin
            n = $fscanf(fd, " %c", kind);
            if (n == 1 && kind == "I") begin
               n = $fscanf(fd, "%h", word);
               program_q.push_back(word);
            end else if (n == 1) begin
               n = $fgets(rest, fd);
            end
         end
         $fclose(fd);
      end
   endtask

   task automatic idle_cycles(input int count);
      i_instr_valid <= 1'b0;
      for (int i = 0; i < count; i++) begin
         @(posedge clk);
      end
   endtask

   // Hold the word until the core takes it
   task automatic send_instr(input ooo_core_pkg::instr_t word, output bit ok);
      int waited;
      waited = 0;
      i_instr <= word;
      i_instr_valid <= 1'b1;
      @(posedge clk);
      while (!o_instr_ready && waited < READY_TIMEOUT) begin
         waited++;
         @(posedge clk);
      end
      ok = o_instr_ready;
      if (!ok) begin
         $display("timeout waiting for o_instr_ready on word %h", word);
         tb_errors++;
      end
   endtask

   task automatic wait_commits();
      int waited;
      waited = 0;
      while (commits < expected && waited < COMMIT_TIMEOUT) begin
         @(posedge clk);
         waited++;
      end
      if (commits < expected) begin
         $display("timeout waiting for the final commit");
      end
   endtask

   task automatic finish_checks();
      int waited;
      waited = 0;
      finish <= 1'b1;
      @(posedge clk);
      while (!finished && waited < FINISH_TIMEOUT) begin
         @(posedge clk);
         waited++;
      end
      if (!finished) begin
         $display("checker did not complete its final checks");
         tb_errors++;
      end
   endtask

   initial begin
      clk = 1'b0;
      nrst = 1'b1;
      i_instr = '0;
      i_instr_valid = 1'b0;
      finish = 1'b0;
      seed = 23398;
      tb_errors = 0;
      aborted = 1'b0;
      load_program();
      for (int i = 0; i < 8; i++) begin
         @(posedge clk);
      end
      nrst <= 1'b0;
      idle_cycles(3);
      for (int k = 0; k < program_q.size(); k++) begin
         if (!aborted) begin
            r = $random(seed);
            if ((r & 7) == 0) begin
               idle_cycles(1 + ((r >> 3) & 1));
            end
            send_instr(program_q[k], accepted);
            if (!accepted) begin
               aborted = 1'b1;
            end
         end
      end
      i_instr_valid <= 1'b0;
      if (!aborted) begin
         wait_commits();
      end
      // Room for any stray commit to show up
      idle_cycles(8);
      finish_checks();
      $display("errors: value %0d, other %0d", value_errors, other_errors + tb_errors);
      if (value_errors + other_errors + tb_errors == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule
